//--- common/ooo_pkg.sv
////////////////////
// ooo core package: sizes, alu op encoding and
// the records passed between rename, issue, alu and rob
////////////////////
package ooo_pkg;

  // machine sizes
  localparam int num_arch_regs = 8;
  localparam int num_phys_regs = 16;
  localparam int rs_depth      = 4;
  localparam int rob_depth     = 8;
  localparam int word_width    = 16;

  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;
  typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;
  typedef logic [$clog2(rob_depth)-1:0]     rob_idx_t;
  typedef logic [$clog2(rs_depth)-1:0]      rs_idx_t;
  typedef logic [word_width-1:0]            word_t;

  // occupancy counters, one bit wider than the index
  typedef logic [$clog2(num_phys_regs):0] fl_count_t;
  typedef logic [$clog2(rob_depth):0]     rob_count_t;

  // op_li ignores both sources
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_li  = 3'd5
  } alu_op_e;

  // decoded op from outside the core
  typedef struct packed {
    alu_op_e   op;
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
    word_t     imm;
  } dispatch_t;

  // op after renaming, as held in the reservation station
  typedef struct packed {
    alu_op_e   op;
    word_t     imm;
    phys_reg_t dest_tag;
    phys_reg_t tag_a;
    phys_reg_t tag_b;
    logic      ready_a;
    logic      ready_b;
    rob_idx_t  rob_idx;
  } rename_t;

  // common data bus, one broadcast per cycle
  typedef struct packed {
    logic      valid;
    phys_reg_t tag;
    rob_idx_t  rob_idx;
    word_t     value;
  } cdb_t;

  // one in-order commit
  typedef struct packed {
    logic      valid;
    arch_reg_t dest;
    word_t     value;
  } retire_t;

  // tag match against the bus
  function automatic logic cdb_hit(cdb_t bus, phys_reg_t tag);
    return bus.valid && (bus.tag == tag);
  endfunction

endpackage

//--- rename/rename_unit.sv
////////////////////
// rename unit: map table, free list of physical
// tags and per-tag ready bits
////////////////////
`timescale 1ns/1ns

module rename_unit (
  input  logic               clock,
  input  logic               reset,
  input  logic               fire,
  input  ooo_pkg::dispatch_t in_op,
  input  ooo_pkg::rob_idx_t  rob_tail,
  input  ooo_pkg::cdb_t      cdb,
  input  logic               free_valid,
  input  ooo_pkg::phys_reg_t free_tag,
  output ooo_pkg::rename_t   renamed,
  output ooo_pkg::phys_reg_t old_tag,
  output logic               free_empty
);
  import ooo_pkg::*;

  // arch to phys mapping
  phys_reg_t map_table [num_arch_regs];

  // circular queue of free tags
  phys_reg_t free_list [num_phys_regs];
  phys_reg_t free_head;
  phys_reg_t free_tail;
  fl_count_t free_count;

  // value present in the register file
  logic [num_phys_regs-1:0] phys_ready;

  phys_reg_t tag_a;
  phys_reg_t tag_b;
  logic      uses_srcs;

  ////////////////////
  // rename lookup
  ////////////////////
  assign tag_a     = map_table[in_op.src_a];
  assign tag_b     = map_table[in_op.src_b];
  assign uses_srcs = (in_op.op != op_li);

  always_comb begin
    renamed.op       = in_op.op;
    renamed.imm      = in_op.imm;
    // new tag from the queue head
    renamed.dest_tag = free_list[free_head];
    renamed.tag_a    = tag_a;
    renamed.tag_b    = tag_b;
    // ready bit or a same-cycle broadcast of the tag
    renamed.ready_a  = !uses_srcs || phys_ready[tag_a] || cdb_hit(cdb, tag_a);
    renamed.ready_b  = !uses_srcs || phys_ready[tag_b] || cdb_hit(cdb, tag_b);
    renamed.rob_idx  = rob_tail;
  end

  // previous mapping goes to the rob, freed at retire
  assign old_tag    = map_table[in_op.dest];
  assign free_empty = (free_count == '0);

  // identity mapping out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        map_table[i] <= phys_reg_t'(i);
      end
    end else if (fire) begin
      map_table[in_op.dest] <= renamed.dest_tag;
    end
  end

  ////////////////////
  // free list
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the arch range start free
      // upper slots wrap to low tags but sit past the tail
      for (int i = 0; i < num_phys_regs; i++) begin
        free_list[i] <= phys_reg_t'(i + num_arch_regs);
      end
      free_head  <= '0;
      free_tail  <= phys_reg_t'(num_phys_regs - num_arch_regs);
      free_count <= fl_count_t'(num_phys_regs - num_arch_regs);
    end else begin
      // push tag released at retire
      if (free_valid) begin
        free_list[free_tail] <= free_tag;
        free_tail            <= free_tail + 1'b1;
      end
      // pop on accept
      if (fire) begin
        free_head <= free_head + 1'b1;
      end
      free_count <= free_count + fl_count_t'(free_valid) - fl_count_t'(fire);
    end
  end

  // ready bits, the bus sets them and allocation clears them
  always_ff @(posedge clock) begin
    if (reset) begin
      phys_ready <= '1;
    end else begin
      if (cdb.valid) begin
        phys_ready[cdb.tag] <= 1'b1;
      end
      // new tag is never in flight, so no clash with the bus
      if (fire) begin
        phys_ready[renamed.dest_tag] <= 1'b0;
      end
    end
  end

endmodule

//--- issue/reservation_station.sv
////////////////////
// reservation station: waits for source tags
// on the bus, issues the lowest ready entry
////////////////////
`timescale 1ns/1ns

module reservation_station (
  input  logic             clock,
  input  logic             reset,
  input  logic             fire,
  input  ooo_pkg::rename_t renamed,
  input  ooo_pkg::cdb_t    cdb,
  output logic             issue_valid,
  output ooo_pkg::rename_t issue_op,
  output logic             rs_full
);
  import ooo_pkg::*;

  logic [rs_depth-1:0] entry_valid;
  rename_t             entry [rs_depth];

  // both operands ready
  logic [rs_depth-1:0] entry_ready;

  rs_idx_t alloc_idx;
  rs_idx_t issue_idx;

  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      entry_ready[i] = entry_valid[i] && entry[i].ready_a && entry[i].ready_b;
    end
  end

  ////////////////////
  // select
  ////////////////////
  // walk down so the lowest index wins
  always_comb begin
    issue_valid = 1'b0;
    issue_idx   = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (entry_ready[i]) begin
        issue_valid = 1'b1;
        issue_idx   = rs_idx_t'(i);
      end
    end
  end

  assign issue_op = entry[issue_idx];

  // lowest free slot for the incoming op
  always_comb begin
    alloc_idx = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!entry_valid[i]) begin
        alloc_idx = rs_idx_t'(i);
      end
    end
  end

  // slot issuing this cycle still counts as taken
  assign rs_full = &entry_valid;

  // occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
    end else begin
      // alu always takes the op
      if (issue_valid) begin
        entry_valid[issue_idx] <= 1'b0;
      end
      if (fire) begin
        entry_valid[alloc_idx] <= 1'b1;
      end
    end
  end

  ////////////////////
  // wakeup
  ////////////////////
  // bus compare on every slot, selectable from the next cycle
  always_ff @(posedge clock) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (cdb_hit(cdb, entry[i].tag_a)) begin
        entry[i].ready_a <= 1'b1;
      end
      if (cdb_hit(cdb, entry[i].tag_b)) begin
        entry[i].ready_b <= 1'b1;
      end
    end
    // same-cycle broadcast already folded into renamed
    if (fire) begin
      entry[alloc_idx] <= renamed;
    end
  end

endmodule

//--- source/alu_exec.sv
////////////////////
// alu stage: physical register file read,
// compute and the common data bus register
////////////////////
`timescale 1ns/1ns

module alu_exec (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  ooo_pkg::rename_t issue_op,
  output ooo_pkg::cdb_t    cdb
);
  import ooo_pkg::*;

  word_t regfile [num_phys_regs];

  word_t opnd_a;
  word_t opnd_b;
  word_t result;

  // bus register
  logic      cdb_valid_q;
  phys_reg_t cdb_tag_q;
  rob_idx_t  cdb_rob_q;
  word_t     cdb_value_q;

  // bypass a tag written this cycle
  assign opnd_a = cdb_hit(cdb, issue_op.tag_a) ? cdb.value : regfile[issue_op.tag_a];
  assign opnd_b = cdb_hit(cdb, issue_op.tag_b) ? cdb.value : regfile[issue_op.tag_b];

  always_comb begin
    case (issue_op.op)
      op_add:  result = opnd_a + opnd_b;
      op_sub:  result = opnd_a - opnd_b;
      op_and:  result = opnd_a & opnd_b;
      op_or:   result = opnd_a | opnd_b;
      op_xor:  result = opnd_a ^ opnd_b;
      op_li:   result = issue_op.imm;
      default: result = '0;
    endcase
  end

  ////////////////////
  // broadcast
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid_q <= 1'b0;
    end else begin
      cdb_valid_q <= issue_valid;
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag_q   <= issue_op.dest_tag;
    cdb_rob_q   <= issue_op.rob_idx;
    cdb_value_q <= result;
  end

  assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, rob_idx: cdb_rob_q, value: cdb_value_q};

  // written at the edge that ends the broadcast
  // arch regs start at zero through the identity map
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        regfile[i] <= '0;
      end
    end else if (cdb_valid_q) begin
      regfile[cdb_tag_q] <= cdb_value_q;
    end
  end

endmodule

//--- rob/reorder_buffer.sv
////////////////////
// reorder buffer: in-order record of accepted ops,
// retires the oldest once its result is on the bus
////////////////////
`timescale 1ns/1ns

module reorder_buffer (
  input  logic               clock,
  input  logic               reset,
  input  logic               fire,
  input  ooo_pkg::arch_reg_t dest,
  input  ooo_pkg::phys_reg_t old_tag,
  input  ooo_pkg::cdb_t      cdb,
  output ooo_pkg::rob_idx_t  rob_tail,
  output logic               rob_full,
  output ooo_pkg::retire_t   retire,
  output logic               free_valid,
  output ooo_pkg::phys_reg_t free_tag
);
  import ooo_pkg::*;

  // per-slot record
  arch_reg_t           entry_dest  [rob_depth];
  phys_reg_t           entry_old   [rob_depth];
  word_t               entry_value [rob_depth];
  logic [rob_depth-1:0] entry_done;

  rob_idx_t   head;
  rob_idx_t   tail;
  rob_count_t count;

  logic head_retire;

  assign rob_tail = tail;
  assign rob_full = (count == rob_count_t'(rob_depth));

  // oldest op has its result
  assign head_retire = (count != '0) && entry_done[head];

  ////////////////////
  // retire
  ////////////////////
  always_comb begin
    retire.valid = head_retire;
    retire.dest  = entry_dest[head];
    retire.value = entry_value[head];
  end

  // old mapping back to the free list on the retire edge
  assign free_valid = head_retire;
  assign free_tag   = entry_old[head];

  // pointers and count
  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (fire) begin
        tail <= tail + 1'b1;
      end
      if (head_retire) begin
        head <= head + 1'b1;
      end
      count <= count + rob_count_t'(fire) - rob_count_t'(head_retire);
    end
  end

  // done flags, set by the bus and cleared on allocation
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_done <= '0;
    end else begin
      if (cdb.valid) begin
        entry_done[cdb.rob_idx] <= 1'b1;
      end
      // tail slot is never in flight when accepting
      if (fire) begin
        entry_done[tail] <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge clock) begin
    if (fire) begin
      entry_dest[tail] <= dest;
      entry_old[tail]  <= old_tag;
    end
    // result capture by slot number
    if (cdb.valid) begin
      entry_value[cdb.rob_idx] <= cdb.value;
    end
  end

endmodule

//--- source/ooo_core.sv
////////////////////
// ooo core top: rename, reservation station,
// alu and rob behind one dispatch handshake
////////////////////
`timescale 1ns/1ns

module ooo_core (
  input  logic               clock,
  input  logic               reset,
  input  logic               in_valid,
  input  ooo_pkg::dispatch_t in_op,
  output logic               in_ready,
  output ooo_pkg::retire_t   retire
);
  import ooo_pkg::*;

  // fullness flags
  logic free_empty;
  logic rs_full;
  logic rob_full;

  // accept strobe shared by all blocks
  logic fire;

  rename_t   renamed;
  phys_reg_t old_tag;
  rob_idx_t  rob_tail;

  logic    issue_valid;
  rename_t issue_op;

  cdb_t cdb;

  // rob to free list
  logic      free_valid;
  phys_reg_t free_tag;

  ////////////////////
  // dispatch handshake
  ////////////////////
  assign in_ready = !free_empty && !rs_full && !rob_full;
  assign fire     = in_valid && in_ready;

  rename_unit rename_unit_inst (
    .clock      (clock),
    .reset      (reset),
    .fire       (fire),
    .in_op      (in_op),
    .rob_tail   (rob_tail),
    .cdb        (cdb),
    .free_valid (free_valid),
    .free_tag   (free_tag),
    .renamed    (renamed),
    .old_tag    (old_tag),
    .free_empty (free_empty)
  );

  reservation_station reservation_station_inst (
    .clock       (clock),
    .reset       (reset),
    .fire        (fire),
    .renamed     (renamed),
    .cdb         (cdb),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .rs_full     (rs_full)
  );

  // single alu, drives the bus
  alu_exec alu_exec_inst (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .cdb         (cdb)
  );

  reorder_buffer reorder_buffer_inst (
    .clock      (clock),
    .reset      (reset),
    .fire       (fire),
    .dest       (in_op.dest),
    .old_tag    (old_tag),
    .cdb        (cdb),
    .rob_tail   (rob_tail),
    .rob_full   (rob_full),
    .retire     (retire),
    .free_valid (free_valid),
    .free_tag   (free_tag)
  );

endmodule

//--- sim/clock_gen.sv
////////////////////
// testbench clock and reset source
////////////////////
`timescale 1ns/1ns

module clock_gen (
  output logic clock,
  output logic reset
);

  // 100 ns period
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // held for 8 rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- sim/ooo_core_tb.sv
////////////////////
// testbench for the ooo core
// applies a table of ops and checks each commit
// against an architectural register model
////////////////////
`timescale 1ns/1ns

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int accept_timeout = 200;
  localparam int commit_timeout = 200;
  localparam int reset_timeout  = 50;

  logic      clock;
  logic      reset;
  logic      in_valid;
  dispatch_t in_op;
  logic      in_ready;
  retire_t   retire;

  // stimulus table with one row per op
  string     names     [$];
  dispatch_t ops       [$];
  arch_reg_t exp_dest  [$];
  word_t     exp_value [$];

  // first row of each test group
  int    group_first [$];
  string group_label [$];

  // commits seen by the monitor
  arch_reg_t got_dest  [$];
  word_t     got_value [$];

  // architectural register model
  word_t model_regs [num_arch_regs];

  integer seed;
  logic   saw_stall;

  clock_gen clock_gen_inst (
    .clock (clock),
    .reset (reset)
  );

  ooo_core ooo_core_inst (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_ready (in_ready),
    .retire   (retire)
  );

  ////////////////////
  // checks
  ////////////////////
  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out while waiting for %s", what);
    $display("Regression failed");
    $fatal(1, "timeout");
  endtask

  ////////////////////
  // reference model and table
  ////////////////////
  function automatic word_t compute_expected(input dispatch_t d);
    word_t a;
    word_t b;
    a = model_regs[d.src_a];
    b = model_regs[d.src_b];
    case (d.op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_li:   return d.imm;
      default: return '0;
    endcase
  endfunction

  task automatic start_group(input string label);
    group_first.push_back(names.size());
    group_label.push_back(label);
  endtask

  // appends a row and its expected commit
  // model follows program order
  task automatic add_entry(input string name, input alu_op_e op, input arch_reg_t dest,
                           input arch_reg_t src_a, input arch_reg_t src_b, input word_t imm);
    dispatch_t d;
    word_t     value;
    d.op    = op;
    d.dest  = dest;
    d.src_a = src_a;
    d.src_b = src_b;
    d.imm   = imm;
    value   = compute_expected(d);
    names.push_back(name);
    ops.push_back(d);
    exp_dest.push_back(dest);
    exp_value.push_back(value);
    model_regs[dest] = value;
  endtask

  task automatic build_table();
    int        sel;
    int        r;
    alu_op_e   burst_op;
    arch_reg_t burst_dest;
    for (int i = 0; i < num_arch_regs; i++) begin
      model_regs[i] = '0;
    end
    // loads then independent alu ops
    start_group("independent");
    add_entry("li_r1", op_li, 3'd1, 3'd0, 3'd0, 16'h1234);
    add_entry("li_r2", op_li, 3'd2, 3'd0, 3'd0, 16'h00ff);
    add_entry("li_r3", op_li, 3'd3, 3'd0, 3'd0, 16'h0f0f);
    add_entry("li_r4", op_li, 3'd4, 3'd0, 3'd0, 16'h8001);
    add_entry("add_r5", op_add, 3'd5, 3'd1, 3'd2, 16'h0000);
    add_entry("sub_r6", op_sub, 3'd6, 3'd1, 3'd4, 16'h0000);
    add_entry("and_r7", op_and, 3'd7, 3'd3, 3'd2, 16'h0000);
    add_entry("or_r0", op_or, 3'd0, 3'd3, 3'd4, 16'h0000);
    add_entry("xor_r1", op_xor, 3'd1, 3'd2, 3'd3, 16'h0000);
    // each op reads the one before
    start_group("chain");
    add_entry("chain_li", op_li, 3'd1, 3'd0, 3'd0, 16'h0003);
    add_entry("chain_add", op_add, 3'd2, 3'd1, 3'd1, 16'h0000);
    add_entry("chain_sub", op_sub, 3'd3, 3'd2, 3'd1, 16'h0000);
    add_entry("chain_xor", op_xor, 3'd4, 3'd3, 3'd2, 16'h0000);
    add_entry("chain_or", op_or, 3'd5, 3'd4, 3'd3, 16'h0000);
    add_entry("chain_and", op_and, 3'd6, 3'd5, 3'd4, 16'h0000);
    add_entry("chain_add2", op_add, 3'd7, 3'd6, 3'd5, 16'h0000);
    // r3 rewritten between its readers
    start_group("rewrite");
    add_entry("rw_li_5", op_li, 3'd3, 3'd0, 3'd0, 16'h0005);
    add_entry("rw_add", op_add, 3'd4, 3'd3, 3'd3, 16'h0000);
    add_entry("rw_li_7", op_li, 3'd3, 3'd0, 3'd0, 16'h0007);
    add_entry("rw_sub", op_sub, 3'd5, 3'd3, 3'd4, 16'h0000);
    add_entry("rw_li_100", op_li, 3'd3, 3'd0, 3'd0, 16'h0100);
    add_entry("rw_or", op_or, 3'd6, 3'd3, 3'd5, 16'h0000);
    add_entry("rw_self", op_add, 3'd3, 3'd3, 3'd3, 16'h0000);
    // dependent burst so issue lags accept and the buffers fill
    start_group("burst");
    for (int k = 0; k < 20; k++) begin
      if (k % 2 == 0) begin
        burst_op   = op_add;
        burst_dest = 3'd1;
      end else begin
        burst_op   = op_sub;
        burst_dest = 3'd2;
      end
      add_entry($sformatf("burst_%0d", k), burst_op, burst_dest, 3'd1, 3'd2, 16'h0000);
    end
    start_group("random");
    for (int k = 0; k < 60; k++) begin
      sel = int'({$random(seed)} % 6);
      r   = $random(seed);
      add_entry($sformatf("random_%0d", k), alu_op_e'(sel[2:0]), r[2:0], r[5:3], r[8:6],
                r[31:16]);
    end
  endtask

  ////////////////////
  // drive and collect
  ////////////////////
  // starts on a falling edge and returns on the falling edge after accept
  task automatic send_op(input int idx);
    int cycles;
    cycles   = 0;
    in_valid = 1'b1;
    in_op    = ops[idx];
    while (!in_ready) begin
      saw_stall = 1'b1;
      @(negedge clock);
      cycles++;
      if (cycles > accept_timeout) report_timeout($sformatf("in_ready for %s", names[idx]));
    end
    @(negedge clock);
  endtask

  task automatic wait_commit(input string name);
    int cycles;
    cycles = 0;
    while (got_value.size() == 0) begin
      @(negedge clock);
      cycles++;
      if (cycles > commit_timeout) report_timeout($sformatf("the commit of %s", name));
    end
  endtask

  // retire is stable over the low phase
  always @(negedge clock) begin
    if (reset === 1'b0 && retire.valid) begin
      got_dest.push_back(retire.dest);
      got_value.push_back(retire.value);
    end
  end

  task automatic run_group(input int g);
    int        first;
    int        last;
    arch_reg_t dest;
    word_t     value;
    first     = group_first[g];
    last      = (g + 1 < group_first.size()) ? group_first[g + 1] : names.size();
    saw_stall = 1'b0;
    for (int i = first; i < last; i++) begin
      send_op(i);
    end
    in_valid = 1'b0;
    // commits come back in table order
    for (int i = first; i < last; i++) begin
      wait_commit(names[i]);
      dest  = got_dest.pop_front();
      value = got_value.pop_front();
      check_value({names[i], " dest"}, word_t'(exp_dest[i]), word_t'(dest));
      check_value({names[i], " value"}, exp_value[i], value);
    end
    if (group_label[g] == "burst") begin
      check_value("burst in_ready dropped", 16'd1, word_t'(saw_stall));
      @(negedge clock);
      check_value("burst in_ready after drain", 16'd1, word_t'(in_ready));
    end
  endtask

  initial begin
    int cycles;
    in_valid = 1'b0;
    in_op    = '0;
    seed     = 49;
    cycles   = 0;
    build_table();
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > reset_timeout) report_timeout("reset to be released");
    end while (reset !== 1'b0);
    // idle core after reset
    for (int c = 0; c < 4; c++) begin
      check_value("reset in_ready", 16'd1, word_t'(in_ready));
      check_value("reset retire valid", 16'd0, word_t'(retire.valid));
      @(negedge clock);
    end
    check_value("reset no commits", 16'd0, word_t'(got_value.size()));
    for (int g = 0; g < group_first.size(); g++) begin
      run_group(g);
    end
    check_value("no extra commits", 16'd0, word_t'(got_value.size()));
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim.f
common/ooo_pkg.sv
rename/rename_unit.sv
issue/reservation_station.sv
source/alu_exec.sv
rob/reorder_buffer.sv
source/ooo_core.sv
sim/clock_gen.sv
sim/ooo_core_tb.sv

//--- run.sh
#!/bin/sh
# build the ooo core testbench with verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module ooo_core_tb -f sim.f \
  && ./obj_dir/Vooo_core_tb > sim.log 2>&1

cat sim.log 2>/dev/null

# a missing log or the fail line means failure
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
